//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fm_monitor_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/fm_config.svh
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// number of monitored clocks
`define FM_NUM_CLOCKS 3

// measurement timer in clk_usb cycles
`define FM_TIMER_WIDTH 14

// rising edge of this bit fires the gate, one every 1024 cycles
`define FM_GATE_BIT 9

`define FM_HEART_BIT 12   // timer heartbeat
`define FM_FLASH_BIT 11   // flash pattern source

// edge counter and latched frequency width
`define FM_COUNT_WIDTH 16

// running edge count bit used as channel heartbeat
`define FM_LED_BIT 4

`endif

//--- project.f
+incdir+include
src/fm_pkg.sv
src/fm_gate_timer.sv
src/fm_channel.sv
src/fm_status_mux.sv
src/fm_monitor_top.sv
tb/fm_monitor_tb.sv

//--- src/fm_channel.sv
`timescale 1ns/10ps
`include "fm_config.svh"

module fm_channel (
   input  logic                       clk_usb,
   input  logic                       reset,
   input  logic                       mon_clk_i,
   input  logic                       gate_i,
   input  logic [`FM_COUNT_WIDTH-1:0] change_limit_i,
   input  logic                       monitor_disable_i,
   output fm_pkg::fm_chan_status_t    status_o
);

   logic                       mon_meta_q;
   logic                       mon_sync_q;
   logic                       mon_prev_q;
   logic                       mon_rise;
   logic [`FM_COUNT_WIDTH-1:0] edge_cnt_q;   // running count in current window
   logic [`FM_COUNT_WIDTH-1:0] freq_q;
   logic                       valid_q;
   logic                       change_q;
   logic [`FM_COUNT_WIDTH-1:0] count_diff;
   logic                       over_limit;

   // monitored clock is treated as a slow async input
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         mon_meta_q <= 1'b0;
         mon_sync_q <= 1'b0;
         mon_prev_q <= 1'b0;
      end
      else begin
         mon_meta_q <= mon_clk_i;
         mon_sync_q <= mon_meta_q;
         mon_prev_q <= mon_sync_q;
      end
   end

   assign mon_rise = mon_sync_q & ~mon_prev_q;

   // edges in the gate cycle belong to the new window
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_cnt_q <= '0;
         freq_q     <= '0;
         valid_q    <= 1'b0;
      end
      else if (gate_i) begin
         edge_cnt_q <= {{(`FM_COUNT_WIDTH-1){1'b0}}, mon_rise};
         freq_q     <= edge_cnt_q;
         valid_q    <= 1'b1;
      end
      else begin
         edge_cnt_q <= edge_cnt_q + {{(`FM_COUNT_WIDTH-1){1'b0}}, mon_rise};
      end
   end

   // absolute difference of new count against last latched one
   always_comb begin
      if (edge_cnt_q > freq_q)
         count_diff = edge_cnt_q - freq_q;
      else
         count_diff = freq_q - edge_cnt_q;
   end

   assign over_limit = count_diff > change_limit_i;

   // first window has nothing to compare with, hence valid
   always_ff @(posedge clk_usb) begin
      if (reset)
         change_q <= 1'b0;
      else if (monitor_disable_i)
         change_q <= 1'b0;
      else if (gate_i && valid_q && over_limit)
         change_q <= 1'b1;
   end

   assign status_o = '{
      freq:      freq_q,
      valid:     valid_q,
      change:    change_q,
      heartbeat: edge_cnt_q[`FM_LED_BIT]
   };

   a_disable_clears : assert property (
      @(posedge clk_usb) disable iff (reset)
      monitor_disable_i |=> !change_q
   );

   // once a window is latched the readout stays valid
   a_valid_sticky : assert property (
      @(posedge clk_usb) disable iff (reset)
      valid_q |=> valid_q
   );

endmodule

//--- src/fm_gate_timer.sv
`timescale 1ns/10ps
`include "fm_config.svh"

module fm_gate_timer (
   input  logic                 clk_usb,
   input  logic                 reset,
   output fm_pkg::fm_timebase_t timebase_o
);

   logic [`FM_TIMER_WIDTH-1:0] timer_q;
   logic                       gate_bit_q;   // delayed copy of the gate bit
   logic                       gate_q;
   logic                       flash_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q    <= '0;
         gate_bit_q <= 1'b0;
         gate_q     <= 1'b0;
      end
      else begin
         timer_q    <= timer_q + 1'b1;
         gate_bit_q <= timer_q[`FM_GATE_BIT];
         gate_q     <= timer_q[`FM_GATE_BIT] & ~gate_bit_q;   // rising edge only
      end
   end

   // flash only moves during the upper half of the timer period
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_q <= 1'b0;
      else if (timer_q[`FM_TIMER_WIDTH-1])
         flash_q <= ~timer_q[`FM_FLASH_BIT];
   end

   assign timebase_o = '{
      gate:      gate_q,
      heartbeat: timer_q[`FM_HEART_BIT],
      flash:     flash_q
   };

   // gate is a single-cycle strobe
   a_gate_single : assert property (
      @(posedge clk_usb) disable iff (reset)
      gate_q |=> !gate_q
   );

endmodule

//--- src/fm_monitor_top.sv
`timescale 1ns/10ps
`include "fm_config.svh"

module fm_monitor_top (
   input  logic                       clk_usb,
   input  logic                       reset,
   input  logic [`FM_NUM_CLOCKS-1:0]  mon_clk_i,
   input  logic [`FM_COUNT_WIDTH-1:0] change_limit_i,
   input  logic                       monitor_disable_i,
   input  logic [1:0]                 freq_sel_i,
   input  fm_pkg::fm_led_mode_t       led_mode_i,
   input  logic                       armed_i,
   input  logic                       capture_i,
   output logic [`FM_COUNT_WIDTH-1:0] freq_o,
   output logic                       ext_change_o,
   output logic                       led_armed_o,
   output logic                       led_capture_o,
   output logic                       gate_o
);

   import fm_pkg::*;

   fm_timebase_t                          timebase;
   fm_chan_status_t [`FM_NUM_CLOCKS-1:0]  chan_status;

   fm_gate_timer u_gate_timer (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .timebase_o (timebase)
   );

   // identical channels, all counting in clk_usb
   for (genvar i = 0; i < `FM_NUM_CLOCKS; i++) begin : g_chan
      fm_channel u_channel (
         .clk_usb           (clk_usb),
         .reset             (reset),
         .mon_clk_i         (mon_clk_i[i]),
         .gate_i            (timebase.gate),
         .change_limit_i    (change_limit_i),
         .monitor_disable_i (monitor_disable_i),
         .status_o          (chan_status[i])
      );
   end

   fm_status_mux u_status_mux (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .chan_status_i     (chan_status),
      .timebase_i        (timebase),
      .freq_sel_i        (freq_sel_i),
      .led_mode_i        (led_mode_i),
      .monitor_disable_i (monitor_disable_i),
      .armed_i           (armed_i),
      .capture_i         (capture_i),
      .freq_o            (freq_o),
      .ext_change_o      (ext_change_o),
      .led_armed_o       (led_armed_o),
      .led_capture_o     (led_capture_o)
   );

   assign gate_o = timebase.gate;   // measurement pulse for outside use

endmodule

//--- src/fm_pkg.sv
`include "fm_config.svh"

package fm_pkg;

   // outputs of the measurement timer
   typedef struct packed {
      logic gate;        // one cycle per measurement window
      logic heartbeat;
      logic flash;
   } fm_timebase_t;

   // per-channel result, one per monitored clock
   typedef struct packed {
      logic [`FM_COUNT_WIDTH-1:0] freq;   // edges in last window
      logic                       valid;  // a window has been latched
      logic                       change; // sticky
      logic                       heartbeat;
   } fm_chan_status_t;

   // LED source selection
   typedef enum logic [1:0] {
      LED_STATUS = 2'd0,
      LED_TIMER  = 2'd1,
      LED_CHAN   = 2'd2,
      LED_EXT    = 2'd3
   } fm_led_mode_t;

endpackage

//--- src/fm_status_mux.sv
`timescale 1ns/10ps
`include "fm_config.svh"

module fm_status_mux (
   input  logic                                           clk_usb,
   input  logic                                           reset,
   input  fm_pkg::fm_chan_status_t [`FM_NUM_CLOCKS-1:0]   chan_status_i,
   input  fm_pkg::fm_timebase_t                           timebase_i,
   input  logic [1:0]                                     freq_sel_i,
   input  fm_pkg::fm_led_mode_t                           led_mode_i,
   input  logic                                           monitor_disable_i,
   input  logic                                           armed_i,
   input  logic                                           capture_i,
   output logic [`FM_COUNT_WIDTH-1:0]                     freq_o,
   output logic                                           ext_change_o,
   output logic                                           led_armed_o,
   output logic                                           led_capture_o
);

   import fm_pkg::*;

   logic any_change;
   logic ext_change_q;

   // frequency readout, zero for unused selections
   always_comb begin
      freq_o = '0;
      if (freq_sel_i < `FM_NUM_CLOCKS)
         freq_o = chan_status_i[freq_sel_i].freq;
   end

   always_comb begin
      any_change = 1'b0;
      for (int i = 0; i < `FM_NUM_CLOCKS; i++)
         any_change = any_change | chan_status_i[i].change;
   end

   // clk_usb copy so a dead monitored clock can still be cleared
   always_ff @(posedge clk_usb) begin
      if (reset)
         ext_change_q <= 1'b0;
      else if (monitor_disable_i)
         ext_change_q <= 1'b0;
      else
         ext_change_q <= any_change;
   end

   assign ext_change_o = ext_change_q;

   always_comb begin
      if (ext_change_q) begin   // change overrides any mode
         led_armed_o   = timebase_i.flash;
         led_capture_o = timebase_i.flash;
      end
      else begin
         case (led_mode_i)
            LED_TIMER: begin
               led_armed_o   = timebase_i.heartbeat;
               led_capture_o = chan_status_i[0].heartbeat;
            end
            LED_CHAN: begin
               led_armed_o   = chan_status_i[1].heartbeat;
               led_capture_o = chan_status_i[2].heartbeat;
            end
            LED_EXT: begin
               led_armed_o   = chan_status_i[2].heartbeat;
               led_capture_o = ext_change_q;
            end
            default: begin
               led_armed_o   = armed_i;
               led_capture_o = capture_i;
            end
         endcase
      end
   end

endmodule

//--- tb/fm_monitor_tb.sv
`timescale 1ns/10ps
`include "fm_config.svh"

module fm_monitor_tb;

   import fm_pkg::*;

   localparam int NUM_ROWS    = 10;
   localparam int GATE_PERIOD = 1 << (`FM_GATE_BIT + 1);   // clk_usb cycles per window
   localparam int CLK_PERIOD  = 8;
   localparam int TIMEOUT_NS  = NUM_ROWS * 4 * GATE_PERIOD * CLK_PERIOD + 4 * CLK_PERIOD;

   typedef struct packed {
      logic [`FM_NUM_CLOCKS-1:0][7:0] half;   // half periods in clk_usb cycles
      logic [`FM_COUNT_WIDTH-1:0]     limit;
      logic                           mon_off;
      fm_led_mode_t                   mode;
      logic                           armed;
      logic                           capture;
      logic                           exp_change;   // ext_change_o once the row settles
   } row_t;

   logic                       clk_usb = 1'b0;
   logic                       reset;
   logic [`FM_NUM_CLOCKS-1:0]  mon_clk = '0;
   logic [`FM_COUNT_WIDTH-1:0] change_limit;
   logic                       monitor_disable;
   logic [1:0]                 freq_sel;
   fm_led_mode_t               led_mode;
   logic                       armed;
   logic                       capture;
   logic [`FM_COUNT_WIDTH-1:0] freq_o;
   logic                       ext_change_o;
   logic                       led_armed_o;
   logic                       led_capture_o;
   logic                       gate_o;

   row_t                      rows [NUM_ROWS];
   int                        cur_half [`FM_NUM_CLOCKS];
   int                        phase_cnt [`FM_NUM_CLOCKS];
   int                        start_phase [`FM_NUM_CLOCKS];
   logic [`FM_NUM_CLOCKS-1:0] start_level;
   logic [15:0]               lfsr_state = 16'd23400;
   int                        err_count = 0;
   int                        since_gate;
   logic                      gate_seen;
   logic                      gate_prev;

   always #(CLK_PERIOD / 2) clk_usb = ~clk_usb;

   fm_monitor_top fm_monitor_top_i (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .mon_clk_i         (mon_clk),
      .change_limit_i    (change_limit),
      .monitor_disable_i (monitor_disable),
      .freq_sel_i        (freq_sel),
      .led_mode_i        (led_mode),
      .armed_i           (armed),
      .capture_i         (capture),
      .freq_o            (freq_o),
      .ext_change_o      (ext_change_o),
      .led_armed_o       (led_armed_o),
      .led_capture_o     (led_capture_o),
      .gate_o            (gate_o)
   );

   task automatic fail_run(input string msg);
      err_count++;
      $display("%s", msg);
      $display("test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_equal(input string name, input int expected, input int actual);
      assert (expected == actual)
         else fail_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                                 $time, name, expected, actual));
   endtask

   // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output int value);
      value = 0;
      for (int b = 0; b < n; b++) begin
         value      = (value << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic row_t make_row(input int h0, input int h1, input int h2, input int limit,
                                     input logic off, input fm_led_mode_t mode,
                                     input logic arm, input logic cap, input logic exp);
      row_t r;
      r.half[0]    = 8'(h0);
      r.half[1]    = 8'(h1);
      r.half[2]    = 8'(h2);
      r.limit      = `FM_COUNT_WIDTH'(limit);
      r.mon_off    = off;
      r.mode       = mode;
      r.armed      = arm;
      r.capture    = cap;
      r.exp_change = exp;
      return r;
   endfunction

   // expected change is sticky until a row with the monitor disabled
   task automatic fill_table();
      rows[0] = make_row(4, 6, 10,  4, 1'b1, LED_STATUS, 1'b1, 1'b0, 1'b0);   // hides first window
      rows[1] = make_row(4, 6, 10,  4, 1'b0, LED_EXT,    1'b0, 1'b1, 1'b0);
      rows[2] = make_row(4, 8, 10,  4, 1'b0, LED_TIMER,  1'b1, 1'b1, 1'b1);   // 85 -> 64
      rows[3] = make_row(4, 8, 10,  4, 1'b1, LED_STATUS, 1'b0, 1'b1, 1'b0);
      rows[4] = make_row(2, 8, 10,  4, 1'b1, LED_EXT,    1'b1, 1'b0, 1'b0);   // masked move
      rows[5] = make_row(2, 8, 12, 16, 1'b0, LED_STATUS, 1'b1, 1'b1, 1'b0);   // 51 -> 42
      rows[6] = make_row(2, 8, 12,  3, 1'b0, LED_CHAN,   1'b0, 1'b1, 1'b0);
      rows[7] = make_row(2, 5, 12,  3, 1'b0, LED_STATUS, 1'b0, 1'b0, 1'b1);   // 64 -> 102
      rows[8] = make_row(2, 5, 12,  3, 1'b0, LED_EXT,    1'b1, 1'b0, 1'b1);
      rows[9] = make_row(2, 5, 12,  3, 1'b1, LED_STATUS, 1'b0, 1'b1, 1'b0);
   endtask

   // returns on the falling edge inside the gate cycle
   task automatic wait_gate();
      do
         @(negedge clk_usb);
      while (gate_o !== 1'b1);
   endtask

   task automatic read_freq_sel(input int sel);
      int expected;
      int actual;
      freq_sel <= 2'(sel);
      @(negedge clk_usb);
      actual = int'(freq_o);
      if (sel < `FM_NUM_CLOCKS) begin
         expected = GATE_PERIOD / (2 * cur_half[sel]);
         assert (actual >= expected - 1 && actual <= expected + 1)
            else fail_run($sformatf("MISMATCH time=%0t freq_o sel=%0d expected=%0d+-1 actual=%0d",
                                    $time, sel, expected, actual));
      end
      else begin
         check_equal("freq_o", 0, actual);   // unused selection
      end
   endtask

   task automatic compare_leds(input row_t row);
      if (row.exp_change) begin
         check_equal("led_capture_o", int'(led_armed_o), int'(led_capture_o));   // flash
      end
      else if (row.mode == LED_STATUS) begin
         check_equal("led_armed_o", int'(row.armed), int'(led_armed_o));
         check_equal("led_capture_o", int'(row.capture), int'(led_capture_o));
      end
      else if (row.mode == LED_EXT) begin
         check_equal("led_capture_o", int'(row.exp_change), int'(led_capture_o));
      end
   endtask

   task automatic run_row(input row_t row);
      @(negedge clk_usb);   // one cycle clear of the gate
      for (int i = 0; i < `FM_NUM_CLOCKS; i++)
         cur_half[i] <= int'(row.half[i]);
      change_limit    <= row.limit;
      monitor_disable <= row.mon_off;
      led_mode        <= row.mode;
      armed           <= row.armed;
      capture         <= row.capture;
      if (row.mon_off) begin
         repeat (2) @(negedge clk_usb);
         check_equal("ext_change_o", 0, int'(ext_change_o));
      end
      wait_gate();
      wait_gate();   // this window ran entirely on the new periods
      repeat (2) @(negedge clk_usb);
      for (int sel = 0; sel <= `FM_NUM_CLOCKS; sel++)
         read_freq_sel(sel);
      check_equal("ext_change_o", int'(row.exp_change), int'(ext_change_o));
      compare_leds(row);
      wait_gate();
      check_equal("ext_change_o", int'(row.exp_change), int'(ext_change_o));
   endtask

   // square waves, phase loaded while reset is high
   always @(negedge clk_usb) begin
      for (int i = 0; i < `FM_NUM_CLOCKS; i++) begin
         if (reset) begin
            phase_cnt[i] <= start_phase[i];
            mon_clk[i]   <= start_level[i];
         end
         else if (phase_cnt[i] + 1 >= cur_half[i]) begin
            phase_cnt[i] <= 0;
            mon_clk[i]   <= ~mon_clk[i];
         end
         else begin
            phase_cnt[i] <= phase_cnt[i] + 1;
         end
      end
   end

   // gate width and spacing
   always @(negedge clk_usb) begin
      if (reset) begin
         since_gate <= 0;
         gate_seen  <= 1'b0;
         gate_prev  <= 1'b0;
      end
      else begin
         if (gate_o) begin
            assert (!gate_prev) else fail_run("gate_o stayed high for more than one cycle");
            if (gate_seen)
               check_equal("gate_o period", GATE_PERIOD, since_gate);
            gate_seen  <= 1'b1;
            since_gate <= 1;
         end
         else begin
            since_gate <= since_gate + 1;
         end
         gate_prev <= gate_o;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      fail_run("watchdog expired before the stimulus table was finished");
   end

   initial begin
      int lvl;
      int ph;
      reset           = 1'b1;
      change_limit    = '0;
      monitor_disable = 1'b0;
      freq_sel        = 2'd0;
      led_mode        = LED_STATUS;
      armed           = 1'b0;
      capture         = 1'b0;
      fill_table();
      for (int i = 0; i < `FM_NUM_CLOCKS; i++) begin
         cur_half[i] = int'(rows[0].half[i]);
         take_bits(1, lvl);
         take_bits(4, ph);
         start_level[i] = lvl[0];
         start_phase[i] = ph % cur_half[i];
      end
      repeat (4) @(negedge clk_usb);
      reset <= 1'b0;
      wait_gate();
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(rows[r]);
      if (err_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
